// ==== logic/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    // Address split
    localparam int VADDR_WIDTH     = 26;
    localparam int PAGE_OFFSET     = 12;
    localparam int VPN_WIDTH       = 14;
    localparam int PPN_WIDTH       = 14;

    // TLB geometry
    localparam int TLB_ENTRIES     = 16;
    localparam int TLB_INDEX_WIDTH = 4;

    // Single-level page table, indexed by the low VPN bits
    localparam int PT_INDEX_WIDTH  = 8;
    localparam int PT_ENTRIES      = 1 << PT_INDEX_WIDTH;
    localparam int PTE_WIDTH       = 32;

    // Page table entry layout
    localparam int PTE_V           = 0;
    localparam int PTE_R           = 1;
    localparam int PTE_W           = 2;
    localparam int PTE_C           = 3;
    localparam int PTE_TAG_LSB     = 4;
    // Upper VPN bits not covered by the table index
    localparam int PTE_TAG_WIDTH   = VPN_WIDTH - PT_INDEX_WIDTH;
    localparam int PTE_PPN_LSB     = 18;

    // Exception codes reported on port 0
    localparam int EXC_WIDTH                   = 3;
    localparam logic [EXC_WIDTH-1:0] EXC_NONE         = 3'd0;
    localparam logic [EXC_WIDTH-1:0] EXC_TLB_MISS     = 3'd1;
    localparam logic [EXC_WIDTH-1:0] EXC_READ_DENIED  = 3'd2;
    localparam logic [EXC_WIDTH-1:0] EXC_WRITE_DENIED = 3'd3;

endpackage

`default_nettype wire

// ==== logic/tlb_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_array import mmu_pkg::*; (
    input  wire                        clk,
    input  wire                        rst,
    input  wire  [VADDR_WIDTH-1:0]     vaddr_0,
    input  wire  [VADDR_WIDTH-1:0]     vaddr_1,
    input  wire                        valid_0,
    input  wire                        valid_1,
    input  wire                        rw,
    input  wire                        flush,
    input  wire                        fill_en,
    input  wire  [VPN_WIDTH-1:0]       fill_vpn,
    input  wire  [PTE_WIDTH-1:0]       fill_pte,
    input  wire  [TLB_INDEX_WIDTH-1:0] fill_index,
    output logic [VADDR_WIDTH-1:0]     paddr_0,
    output logic [VADDR_WIDTH-1:0]     paddr_1,
    output logic                       paddr_valid_0,
    output logic                       paddr_valid_1,
    output logic                       hit,
    output logic                       pcd,
    output logic                       exception,
    output logic [EXC_WIDTH-1:0]       exception_type,
    output logic                       miss_0,
    output logic                       miss_1
);

    // Entry storage, only the valid bits are reset
    logic [TLB_ENTRIES-1:0] ent_valid;
    logic [VPN_WIDTH-1:0]   ent_vpn [TLB_ENTRIES];
    logic [PPN_WIDTH-1:0]   ent_ppn [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] ent_r;
    logic [TLB_ENTRIES-1:0] ent_w;
    logic [TLB_ENTRIES-1:0] ent_c;

    logic [VPN_WIDTH-1:0]       vpn_0;
    logic [VPN_WIDTH-1:0]       vpn_1;
    logic                       hit_0;
    logic                       hit_1;
    logic [TLB_INDEX_WIDTH-1:0] idx_0;
    logic [TLB_INDEX_WIDTH-1:0] idx_1;
    logic                       perm_ok;

    assign vpn_0 = vaddr_0[VADDR_WIDTH-1:PAGE_OFFSET];
    assign vpn_1 = vaddr_1[VADDR_WIDTH-1:PAGE_OFFSET];

    // Parallel search of all entries for both ports
    always_comb begin
        hit_0 = 1'b0;
        hit_1 = 1'b0;
        idx_0 = '0;
        idx_1 = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (ent_valid[i] && (ent_vpn[i] == vpn_0)) begin
                hit_0 = 1'b1;
                idx_0 = TLB_INDEX_WIDTH'(i);
            end
            if (ent_valid[i] && (ent_vpn[i] == vpn_1)) begin
                hit_1 = 1'b1;
                idx_1 = TLB_INDEX_WIDTH'(i);
            end
        end
    end

    // Miss passes the virtual address straight through
    assign paddr_0 = hit_0 ? {ent_ppn[idx_0], vaddr_0[PAGE_OFFSET-1:0]} : vaddr_0;
    assign paddr_1 = hit_1 ? {ent_ppn[idx_1], vaddr_1[PAGE_OFFSET-1:0]} : vaddr_1;
    assign paddr_valid_0 = hit_0;
    assign paddr_valid_1 = hit_1;

    assign miss_0 = valid_0 && !hit_0;
    assign miss_1 = valid_1 && !hit_1;

    // Data port status
    assign hit = hit_0;
    assign pcd = hit_0 ? !ent_c[idx_0] : 1'b1;
    assign perm_ok = rw ? ent_w[idx_0] : ent_r[idx_0];
    assign exception = valid_0 && (!hit_0 || !perm_ok);

    always_comb begin
        exception_type = EXC_NONE;
        if (exception) begin
            if (!hit_0)
                exception_type = EXC_TLB_MISS;
            else if (rw)
                exception_type = EXC_WRITE_DENIED;
            else
                exception_type = EXC_READ_DENIED;
        end
    end

    // A refill on the same edge as a flush still lands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid <= '0;
        end else begin
            if (flush)
                ent_valid <= '0;
            if (fill_en)
                ent_valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            ent_vpn[fill_index] <= fill_vpn;
            ent_ppn[fill_index] <= fill_pte[PTE_PPN_LSB +: PPN_WIDTH];
            ent_r[fill_index]   <= fill_pte[PTE_R];
            ent_w[fill_index]   <= fill_pte[PTE_W];
            ent_c[fill_index]   <= fill_pte[PTE_C];
        end
    end

endmodule

`default_nettype wire

// ==== logic/page_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_walker import mmu_pkg::*; (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        miss_0,
    input  wire                        miss_1,
    input  wire  [VADDR_WIDTH-1:0]     vaddr_0,
    input  wire  [VADDR_WIDTH-1:0]     vaddr_1,
    input  wire                        walk_gnt,
    input  wire  [PTE_WIDTH-1:0]       mem_rdata,
    output logic                       walk_req,
    output logic [PT_INDEX_WIDTH-1:0]  walk_addr,
    output logic                       fill_en,
    output logic [VPN_WIDTH-1:0]       fill_vpn,
    output logic [PTE_WIDTH-1:0]       fill_pte,
    output logic [TLB_INDEX_WIDTH-1:0] fill_index,
    output logic                       walk_busy,
    output logic                       walk_fault
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_FINISH
    } walk_state_t;

    walk_state_t                state;
    logic [VPN_WIDTH-1:0]       vpn_q;
    logic [PTE_WIDTH-1:0]       pte_q;
    logic [TLB_INDEX_WIDTH-1:0] rr_ptr;
    logic                       pte_ok;

    // Entry must be valid and its tag must match the upper VPN bits
    assign pte_ok = pte_q[PTE_V] &&
        (pte_q[PTE_TAG_LSB +: PTE_TAG_WIDTH] == vpn_q[VPN_WIDTH-1 -: PTE_TAG_WIDTH]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            rr_ptr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (miss_0 || miss_1)
                        state <= ST_REQ;
                end
                ST_REQ: begin
                    if (walk_gnt)
                        state <= ST_WAIT;
                end
                // Read data is valid one cycle after the grant
                ST_WAIT: state <= ST_FINISH;
                ST_FINISH: begin
                    state <= ST_IDLE;
                    if (pte_ok)
                        rr_ptr <= rr_ptr + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Port 0 wins when both ports miss
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && (miss_0 || miss_1))
            vpn_q <= miss_0 ? vaddr_0[VADDR_WIDTH-1:PAGE_OFFSET]
                            : vaddr_1[VADDR_WIDTH-1:PAGE_OFFSET];
        if (state == ST_WAIT)
            pte_q <= mem_rdata;
    end

    assign walk_req   = (state == ST_REQ);
    assign walk_addr  = vpn_q[PT_INDEX_WIDTH-1:0];
    assign walk_busy  = (state != ST_IDLE);
    assign fill_en    = (state == ST_FINISH) && pte_ok;
    assign walk_fault = (state == ST_FINISH) && !pte_ok;
    assign fill_vpn   = vpn_q;
    assign fill_pte   = pte_q;
    assign fill_index = rr_ptr;

endmodule

`default_nettype wire

// ==== logic/pt_port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pt_port_arbiter import mmu_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       host_wr_en,
    input  wire  [PT_INDEX_WIDTH-1:0] host_wr_addr,
    input  wire  [PTE_WIDTH-1:0]      host_wr_data,
    input  wire                       walk_req,
    input  wire  [PT_INDEX_WIDTH-1:0] walk_addr,
    output logic                      walk_gnt,
    output logic                      mem_en,
    output logic                      mem_we,
    output logic [PT_INDEX_WIDTH-1:0] mem_addr,
    output logic [PTE_WIDTH-1:0]      mem_wdata
);

    // High in the cycle after a walker grant, while its read returns
    logic rd_pending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_pending <= 1'b0;
        else
            rd_pending <= walk_gnt;
    end

    // Host writes take the memory whenever they appear
    assign walk_gnt = walk_req && !host_wr_en && !rd_pending;

    assign mem_en    = host_wr_en || walk_gnt;
    assign mem_we    = host_wr_en;
    assign mem_addr  = host_wr_en ? host_wr_addr : walk_addr;
    assign mem_wdata = host_wr_data;

endmodule

`default_nettype wire

// ==== logic/page_table_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_table_mem import mmu_pkg::*; (
    input  wire                       clk,
    input  wire                       mem_en,
    input  wire                       mem_we,
    input  wire  [PT_INDEX_WIDTH-1:0] mem_addr,
    input  wire  [PTE_WIDTH-1:0]      mem_wdata,
    output logic [PTE_WIDTH-1:0]      mem_rdata
);

    logic [PTE_WIDTH-1:0] table_q [PT_ENTRIES];

    // Single port, read data registered on the access edge
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we)
                table_q[mem_addr] <= mem_wdata;
            else
                mem_rdata <= table_q[mem_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mmu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_top import mmu_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  [VADDR_WIDTH-1:0]    vaddr_0,
    input  wire                       valid_0,
    input  wire                       rw,
    input  wire  [VADDR_WIDTH-1:0]    vaddr_1,
    input  wire                       valid_1,
    output logic [VADDR_WIDTH-1:0]    paddr_0,
    output logic                      paddr_valid_0,
    output logic [VADDR_WIDTH-1:0]    paddr_1,
    output logic                      paddr_valid_1,
    output logic                      hit,
    output logic                      pcd,
    output logic                      exception,
    output logic [EXC_WIDTH-1:0]      exception_type,
    input  wire                       flush,
    input  wire                       host_wr_en,
    input  wire  [PT_INDEX_WIDTH-1:0] host_wr_addr,
    input  wire  [PTE_WIDTH-1:0]      host_wr_data,
    output logic                      walk_busy,
    output logic                      walk_fault
);

    // TLB refill path
    logic                       miss_0;
    logic                       miss_1;
    logic                       fill_en;
    logic [VPN_WIDTH-1:0]       fill_vpn;
    logic [PTE_WIDTH-1:0]       fill_pte;
    logic [TLB_INDEX_WIDTH-1:0] fill_index;

    // Page table memory path
    logic                       walk_req;
    logic [PT_INDEX_WIDTH-1:0]  walk_addr;
    logic                       walk_gnt;
    logic                       mem_en;
    logic                       mem_we;
    logic [PT_INDEX_WIDTH-1:0]  mem_addr;
    logic [PTE_WIDTH-1:0]       mem_wdata;
    logic [PTE_WIDTH-1:0]       mem_rdata;

    tlb_array u_tlb (
        .clk            (clk),
        .rst            (rst),
        .vaddr_0        (vaddr_0),
        .vaddr_1        (vaddr_1),
        .valid_0        (valid_0),
        .valid_1        (valid_1),
        .rw             (rw),
        .flush          (flush),
        .fill_en        (fill_en),
        .fill_vpn       (fill_vpn),
        .fill_pte       (fill_pte),
        .fill_index     (fill_index),
        .paddr_0        (paddr_0),
        .paddr_1        (paddr_1),
        .paddr_valid_0  (paddr_valid_0),
        .paddr_valid_1  (paddr_valid_1),
        .hit            (hit),
        .pcd            (pcd),
        .exception      (exception),
        .exception_type (exception_type),
        .miss_0         (miss_0),
        .miss_1         (miss_1)
    );

    page_walker u_walker (
        .clk        (clk),
        .rst        (rst),
        .miss_0     (miss_0),
        .miss_1     (miss_1),
        .vaddr_0    (vaddr_0),
        .vaddr_1    (vaddr_1),
        .walk_gnt   (walk_gnt),
        .mem_rdata  (mem_rdata),
        .walk_req   (walk_req),
        .walk_addr  (walk_addr),
        .fill_en    (fill_en),
        .fill_vpn   (fill_vpn),
        .fill_pte   (fill_pte),
        .fill_index (fill_index),
        .walk_busy  (walk_busy),
        .walk_fault (walk_fault)
    );

    pt_port_arbiter u_arb (
        .clk          (clk),
        .rst          (rst),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .walk_req     (walk_req),
        .walk_addr    (walk_addr),
        .walk_gnt     (walk_gnt),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    page_table_mem u_ptmem (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== sim/mmu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_sva (
    input wire clk,
    input wire rst,
    input wire walk_req,
    input wire walk_gnt,
    input wire host_wr_en,
    input wire fill_en,
    input wire walk_fault,
    input wire walk_busy
);

    // Walker keeps asking until it is served
    assert property (@(posedge clk) disable iff (rst) walk_req && !walk_gnt |=> walk_req)
        else $error("walk_req dropped before walk_gnt");

    // Host write always owns the memory
    assert property (@(posedge clk) disable iff (rst) !(walk_gnt && host_wr_en))
        else $error("walk_gnt together with host_wr_en");

    assert property (@(posedge clk) disable iff (rst) !(fill_en && walk_fault))
        else $error("fill_en together with walk_fault");

    assert property (@(posedge clk) disable iff (rst) fill_en |-> walk_busy)
        else $error("fill_en outside a walk");

endmodule

bind mmu_top mmu_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .walk_req   (walk_req),
    .walk_gnt   (walk_gnt),
    .host_wr_en (host_wr_en),
    .fill_en    (fill_en),
    .walk_fault (walk_fault),
    .walk_busy  (walk_busy)
);

`default_nettype wire

// ==== sim/mmu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmu_tb import mmu_pkg::*; ();

    localparam int N_PAGES    = 40;
    localparam int N_OPS      = PT_ENTRIES + 4 * N_PAGES + 32;
    localparam int WALK_LIMIT = 40;

    logic                      clk;
    logic                      rst;
    logic [VADDR_WIDTH-1:0]    vaddr_0;
    logic [VADDR_WIDTH-1:0]    vaddr_1;
    logic                      valid_0;
    logic                      valid_1;
    logic                      rw;
    logic                      flush;
    logic                      host_wr_en;
    logic [PT_INDEX_WIDTH-1:0] host_wr_addr;
    logic [PTE_WIDTH-1:0]      host_wr_data;
    wire  [VADDR_WIDTH-1:0]    paddr_0;
    wire  [VADDR_WIDTH-1:0]    paddr_1;
    wire                       paddr_valid_0;
    wire                       paddr_valid_1;
    wire                       hit;
    wire                       pcd;
    wire                       exception;
    wire  [EXC_WIDTH-1:0]      exception_type;
    wire                       walk_busy;
    wire                       walk_fault;

    // Reference model of the page table and the TLB
    logic [PTE_WIDTH-1:0] pt_model [PT_ENTRIES];
    logic                 m_valid  [TLB_ENTRIES];
    logic [VPN_WIDTH-1:0] m_vpn    [TLB_ENTRIES];
    logic [PTE_WIDTH-1:0] m_pte    [TLB_ENTRIES];
    int                   rr;
    logic [VPN_WIDTH-1:0] pages    [N_PAGES];
    bit                   noise_on;

    mmu_top UUT (
        .clk(clk), .rst(rst),
        .vaddr_0(vaddr_0), .valid_0(valid_0), .rw(rw),
        .vaddr_1(vaddr_1), .valid_1(valid_1),
        .paddr_0(paddr_0), .paddr_valid_0(paddr_valid_0),
        .paddr_1(paddr_1), .paddr_valid_1(paddr_valid_1),
        .hit(hit), .pcd(pcd), .exception(exception), .exception_type(exception_type),
        .flush(flush), .host_wr_en(host_wr_en), .host_wr_addr(host_wr_addr),
        .host_wr_data(host_wr_data), .walk_busy(walk_busy), .walk_fault(walk_fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (N_OPS * 20) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic tlb_has(input logic [VPN_WIDTH-1:0] vpn);
        logic found;
        found = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++)
            if (m_valid[i] && m_vpn[i] == vpn)
                found = 1'b1;
        return found;
    endfunction

    // Packed as {paddr, paddr_valid, pcd, exception, exception_type}
    function automatic logic [31:0] expect_lookup(input logic [VADDR_WIDTH-1:0] va,
                                                  input logic v, input logic wr);
        logic [VPN_WIDTH-1:0]   vpn;
        logic                   found;
        logic [PTE_WIDTH-1:0]   pte;
        logic                   ok;
        logic [EXC_WIDTH-1:0]   et;
        logic [VADDR_WIDTH-1:0] pa;
        logic                   nc;
        vpn = va[VADDR_WIDTH-1:PAGE_OFFSET];
        found = 1'b0;
        pte = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (m_valid[i] && m_vpn[i] == vpn) begin
                found = 1'b1;
                pte = m_pte[i];
            end
        end
        pa = found ? {pte[PTE_PPN_LSB +: PPN_WIDTH], va[PAGE_OFFSET-1:0]} : va;
        nc = found ? !pte[PTE_C] : 1'b1;
        ok = wr ? pte[PTE_W] : pte[PTE_R];
        et = EXC_NONE;
        if (v && !found)
            et = EXC_TLB_MISS;
        else if (v && !ok)
            et = wr ? EXC_WRITE_DENIED : EXC_READ_DENIED;
        return {pa, found, nc, (et != EXC_NONE), et};
    endfunction

    // Outputs settle on the old inputs before the falling-edge drive lands
    always @(negedge clk) begin : compare_outputs
        logic [31:0] e0;
        logic [31:0] e1;
        if (!rst) begin
            e0 = expect_lookup(vaddr_0, valid_0, rw);
            e1 = expect_lookup(vaddr_1, valid_1, 1'b0);
            check_value("paddr_0", 32'(paddr_0), 32'(e0[31:6]));
            check_value("paddr_valid_0", 32'(paddr_valid_0), 32'(e0[5]));
            check_value("hit", 32'(hit), 32'(e0[5]));
            check_value("pcd", 32'(pcd), 32'(e0[4]));
            check_value("exception", 32'(exception), 32'(e0[3]));
            check_value("exception_type", 32'(exception_type), 32'(e0[2:0]));
            check_value("paddr_1", 32'(paddr_1), 32'(e1[31:6]));
            check_value("paddr_valid_1", 32'(paddr_valid_1), 32'(e1[5]));
        end
    end

    // Random host writes into the upper half of the table, never walked
    always @(negedge clk) begin : host_noise
        logic                      en;
        logic [PT_INDEX_WIDTH-1:0] a;
        logic [PTE_WIDTH-1:0]      d;
        if (noise_on) begin
            en = 1'($urandom);
            a = 8'(128 + $urandom % 128);
            d = $urandom;
            host_wr_en <= en;
            host_wr_addr <= a;
            host_wr_data <= d;
            if (en)
                pt_model[a] = d;
        end
    end

    function automatic logic [PTE_WIDTH-1:0] make_pte(input logic [VPN_WIDTH-1:0] vpn,
                                                      input logic [PPN_WIDTH-1:0] ppn,
                                                      input logic [3:0] flags,
                                                      input logic bad_tag);
        return {ppn, 8'h00, vpn[13:8] ^ {5'b0, bad_tag}, flags};
    endfunction

    task automatic host_write(input logic [PT_INDEX_WIDTH-1:0] a, input logic [PTE_WIDTH-1:0] d);
        @(negedge clk);
        host_wr_en <= 1'b1;
        host_wr_addr <= a;
        host_wr_data <= d;
        pt_model[a] = d;
    endtask

    task automatic host_idle();
        @(negedge clk);
        host_wr_en <= 1'b0;
    endtask

    task automatic model_walk(input logic [VPN_WIDTH-1:0] vpn, output logic fault);
        logic [PTE_WIDTH-1:0] pte;
        pte = pt_model[vpn[PT_INDEX_WIDTH-1:0]];
        fault = !(pte[PTE_V] && pte[9:4] == vpn[13:8]);
        if (!fault) begin
            m_valid[rr] = 1'b1;
            m_vpn[rr] = vpn;
            m_pte[rr] = pte;
            rr = (rr + 1) % TLB_ENTRIES;
        end
    endtask

    // One lookup cycle, followed by the walk that a predicted miss starts
    task automatic access(input logic [VADDR_WIDTH-1:0] va0, input logic v0,
                          input logic [VADDR_WIDTH-1:0] va1, input logic v1,
                          input logic wr);
        logic                 walk;
        logic [VPN_WIDTH-1:0] vpn;
        logic                 fault;
        logic                 seen;
        int                   cycles;
        walk = 1'b0;
        vpn = '0;
        seen = 1'b0;
        cycles = 0;
        if (v0 && !tlb_has(va0[VADDR_WIDTH-1:PAGE_OFFSET])) begin
            walk = 1'b1;
            vpn = va0[VADDR_WIDTH-1:PAGE_OFFSET];
        end else if (v1 && !tlb_has(va1[VADDR_WIDTH-1:PAGE_OFFSET])) begin
            walk = 1'b1;
            vpn = va1[VADDR_WIDTH-1:PAGE_OFFSET];
        end
        @(negedge clk);
        vaddr_0 <= va0;
        valid_0 <= v0;
        vaddr_1 <= va1;
        valid_1 <= v1;
        rw <= wr;
        @(negedge clk);
        valid_0 <= 1'b0;
        valid_1 <= 1'b0;
        // A hit or an idle port must leave the walker alone
        check_value("walk_busy", 32'(walk_busy), 32'(walk));
        if (walk) begin
            while (walk_busy) begin
                @(posedge clk);
                #1;
                if (walk_fault)
                    seen = 1'b1;
                cycles++;
                if (cycles > WALK_LIMIT) begin
                    $display("Page walk did not finish, walk_busy stayed high");
                    $display("SIMULATION FAILED");
                    $fatal(1);
                end
            end
            model_walk(vpn, fault);
            check_value("walk_fault", 32'(seen), 32'(fault));
        end
    endtask

    task automatic do_flush();
        @(negedge clk);
        flush <= 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < TLB_ENTRIES; i++)
            m_valid[i] = 1'b0;
        @(negedge clk);
        flush <= 1'b0;
    endtask

    function automatic logic [VADDR_WIDTH-1:0] page_addr(input int idx);
        return {pages[idx], 12'($urandom)};
    endfunction

    initial begin
        void'($urandom(32'h8c7f));
        rst = 1'b1;
        vaddr_0 = '0;
        vaddr_1 = '0;
        valid_0 = 1'b0;
        valid_1 = 1'b0;
        rw = 1'b0;
        flush = 1'b0;
        host_wr_en = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        noise_on = 1'b0;
        rr = 0;
        for (int i = 0; i < TLB_ENTRIES; i++)
            m_valid[i] = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;

        // Empty TLB, lookups without a request
        repeat (4) access(26'($urandom), 1'b0, 26'($urandom), 1'b0, 1'($urandom));

        // Cleared table, every walk faults
        for (int i = 0; i < PT_ENTRIES; i++)
            host_write(8'(i), '0);
        host_idle();
        repeat (4) access(26'($urandom), 1'b1, 26'($urandom), 1'b1, 1'($urandom));

        // Pages with mixed flags, some invalid and some with a wrong tag
        for (int i = 0; i < N_PAGES; i++) begin
            pages[i] = {6'($urandom), 8'(i)};
            host_write(8'(i), make_pte(pages[i], 14'($urandom),
                       {3'($urandom), 1'(i % 7 != 3)}, 1'(i % 11 == 5)));
        end
        host_idle();

        // Walks from both ports, more pages than entries
        for (int i = 0; i < N_PAGES; i++) begin
            if (i % 2 == 0)
                access(page_addr(i), 1'b1, 26'($urandom), 1'b0, 1'($urandom));
            else
                access(26'($urandom), 1'b0, page_addr(i), 1'b1, 1'b0);
            access(page_addr(i), 1'b1, page_addr(i), 1'b0, 1'($urandom));
        end

        // Both ports active while the host writes
        @(posedge clk);
        noise_on = 1'b1;
        for (int i = 0; i < N_PAGES; i++)
            access(page_addr($urandom % N_PAGES), 1'b1, page_addr($urandom % N_PAGES), 1'b1,
                   1'($urandom));
        @(posedge clk);
        noise_on = 1'b0;
        host_idle();

        do_flush();
        for (int i = 0; i < 4; i++)
            access(page_addr(i), 1'b0, page_addr(i + 1), 1'b0, 1'b0);
        for (int i = 0; i < N_PAGES; i++)
            access(page_addr($urandom % N_PAGES), 1'($urandom), page_addr(i), 1'b1,
                   1'($urandom));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mmu_top.f ====
logic/mmu_pkg.sv
logic/tlb_array.sv
logic/page_walker.sv
logic/pt_port_arbiter.sv
logic/page_table_mem.sv
logic/mmu_top.sv
sim/mmu_sva.sv
sim/mmu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= mmu_tb
FILELIST  ?= mmu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
